/* sim.f */
+incdir+verif
source/muldiv_pkg.sv
source/mul_unit.sv
source/div_unit.sv
source/muldiv_ctrl.sv
source/muldiv_top.sv
verif/muldiv_tb.sv

/* verif/muldiv_ref.svh */
`ifndef MULDIV_REF_SVH
`define MULDIV_REF_SVH

// expected RV32M result, worked out in double width
function automatic xlen_word_t muldiv_ref(input muldiv_op_t op, input xlen_word_t a,
		input xlen_word_t b);
	logic signed [2*XLEN-1:0] sa;
	logic signed [2*XLEN-1:0] sb;
	logic signed [2*XLEN-1:0] ua;
	logic signed [2*XLEN-1:0] ub;
	logic signed [2*XLEN-1:0] res;
	logic                     hi;
	sa = {{XLEN{a[XLEN-1]}}, a};
	sb = {{XLEN{b[XLEN-1]}}, b};
	ua = {{XLEN{1'b0}}, a};
	ub = {{XLEN{1'b0}}, b};
	hi = 1'b0;
	// divide by zero
	if ((op == op_div || op == op_divu) && b == '0)
		return '1;
	if ((op == op_rem || op == op_remu) && b == '0)
		return a;
	// min / -1 wraps to min in the low half of the wide quotient
	case (op)
		op_mul: res = sa * sb;
		op_mulh: begin
			res = sa * sb;
			hi = 1'b1;
		end
		op_mulhsu: begin
			res = sa * ub;
			hi = 1'b1;
		end
		op_mulhu: begin
			res = ua * ub;
			hi = 1'b1;
		end
		op_div: res = sa / sb;
		op_divu: res = ua / ub;
		op_rem: res = sa % sb;
		default: res = ua % ub;
	endcase
	if (hi)
		return res[2*XLEN-1:XLEN];
	else
		return res[XLEN-1:0];
endfunction

`endif

/* verif/muldiv_tb.sv */
module muldiv_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import muldiv_pkg::*;

	`include "muldiv_ref.svh"

	localparam int CLK_PERIOD = 20;
	localparam int N_VALS = 7;
	localparam int N_DIRECTED = N_VALS * N_VALS * 8;
	localparam int N_RANDOM = 300;
	localparam int N_STALLED = 80;
	localparam int N_REQ = N_DIRECTED + N_RANDOM + N_STALLED;
	// request gap plus response stall, worst case
	localparam int MAX_GAP = 12;
	localparam int WATCHDOG_NS = (N_REQ * (XLEN + 4 + MAX_GAP) + 10) * CLK_PERIOD;

	logic       clk_i;
	logic       rst_n_i;
	logic       req_valid_i;
	logic       req_ready_o;
	muldiv_op_t req_op_i;
	xlen_word_t req_rs1_i;
	xlen_word_t req_rs2_i;
	logic       resp_valid_o;
	logic       resp_ready_i;
	xlen_word_t resp_result_o;

	integer seed = 32'hc29f6c12;
	int     errors = 0;
	int     checks = 0;
	int     n_sent = 0;
	int     n_done = 0;
	logic   stall_en = 1'b0;

	// outstanding requests, oldest first
	xlen_word_t exp_q[$];
	muldiv_op_t op_q[$];
	xlen_word_t rs1_q[$];
	xlen_word_t rs2_q[$];

	xlen_word_t vals [N_VALS] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff,
		32'h8000_0000, 32'h7fff_ffff, 32'hffff_fff9, 32'h0000_0003};

	muldiv_top i_dut (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.req_valid_i   (req_valid_i),
		.req_ready_o   (req_ready_o),
		.req_op_i      (req_op_i),
		.req_rs1_i     (req_rs1_i),
		.req_rs2_i     (req_rs2_i),
		.resp_valid_o  (resp_valid_o),
		.resp_ready_i  (resp_ready_i),
		.resp_result_o (resp_result_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
	end

	// called 2 ns after a rising edge, returns 2 ns after the accept edge
	task automatic send_req(input muldiv_op_t op, input xlen_word_t a, input xlen_word_t b);
		logic acc;
		acc = 1'b0;
		req_valid_i = 1'b1;
		req_op_i = op;
		req_rs1_i = a;
		req_rs2_i = b;
		while (!acc) begin
			@(negedge clk_i);
			acc = req_ready_o;
			@(posedge clk_i);
		end
		exp_q.push_back(muldiv_ref(op, a, b));
		op_q.push_back(op);
		rs1_q.push_back(a);
		rs2_q.push_back(b);
		n_sent++;
		#2;
		req_valid_i = 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk_i);
			#2;
		end
	endtask

	task automatic send_random(input int max_gap);
		integer     r;
		xlen_word_t a;
		xlen_word_t b;
		r = $random(seed);
		a = $random(seed);
		b = $random(seed);
		send_req(muldiv_op_t'(r[2:0]), a, b);
		r = $random(seed);
		idle_cycles(r[1:0] % (max_gap + 1));
	endtask

	initial begin
		rst_n_i = 1'b0;
		req_valid_i = 1'b0;
		req_op_i = op_mul;
		req_rs1_i = '0;
		req_rs2_i = '0;
		repeat (2) @(posedge clk_i);
		#2;
		rst_n_i = 1'b1;
		@(negedge clk_i);
		assert (req_ready_o === 1'b1 && resp_valid_o === 1'b0)
		else begin
			$display("the unit is not idle after reset at %0t", $time);
			errors++;
		end
		@(posedge clk_i);
		#2;
		// every op over every pair of edge values
		for (int k = 0; k < 8; k++)
			for (int i = 0; i < N_VALS; i++)
				for (int j = 0; j < N_VALS; j++)
					send_req(muldiv_op_t'(k), vals[i], vals[j]);
		for (int n = 0; n < N_RANDOM; n++)
			send_random(3);
		stall_en = 1'b1;
		for (int n = 0; n < N_STALLED; n++)
			send_random(3);
		wait (n_done == n_sent);
		stall_en = 1'b0;
		repeat (4) @(posedge clk_i);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0 && checks == N_REQ)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// response back-pressure in random stretches
	initial begin
		int     stall;
		integer r;
		stall = 0;
		resp_ready_i = 1'b1;
		forever begin
			// drawn away from the stimulus edge
			@(negedge clk_i);
			r = $random(seed);
			@(posedge clk_i);
			#2;
			if (!stall_en) begin
				resp_ready_i = 1'b1;
			end else if (stall > 0) begin
				resp_ready_i = 1'b0;
				stall--;
			end else begin
				if (r[1:0] == 2'b00) begin
					stall = r[4:2];
					resp_ready_i = 1'b0;
				end else begin
					resp_ready_i = 1'b1;
				end
			end
		end
	end

	initial begin
		logic       held;
		xlen_word_t held_val;
		xlen_word_t expected;
		xlen_word_t a;
		xlen_word_t b;
		muldiv_op_t op;
		held = 1'b0;
		held_val = '0;
		@(posedge rst_n_i);
		forever begin
			@(negedge clk_i);
			assert (!(resp_valid_o && req_ready_o))
			else begin
				$display("req_ready_o is high while a response waits at %0t", $time);
				errors++;
			end
			if (!resp_valid_o) begin
				assert (!held)
				else begin
					$display("resp_valid_o dropped at %0t before the response was taken",
						$time);
					errors++;
				end
				held = 1'b0;
			end else begin
				if (held)
					assert (resp_result_o === held_val)
					else begin
						$display("error at %0t: held result changed from %h to %h",
							$time, held_val, resp_result_o);
						errors++;
					end
				held = !resp_ready_i;
				held_val = resp_result_o;
				if (resp_ready_i && exp_q.size() == 0) begin
					$display("a response arrived at %0t with no request outstanding", $time);
					errors++;
				end else if (resp_ready_i) begin
					expected = exp_q.pop_front();
					op = op_q.pop_front();
					a = rs1_q.pop_front();
					b = rs2_q.pop_front();
					checks++;
					assert (resp_result_o === expected)
					else begin
						$display("error at %0t: %s rs1=%h rs2=%h expected %h got %h",
							$time, op.name(), a, b, expected, resp_result_o);
						errors++;
					end
					n_done++;
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

/* source/muldiv_top.sv */
module muldiv_top (
	input  logic                   clk_i,
	input  logic                   rst_n_i,
	input  logic                   req_valid_i,
	output logic                   req_ready_o,
	input  muldiv_pkg::muldiv_op_t req_op_i,
	input  muldiv_pkg::xlen_word_t req_rs1_i,
	input  muldiv_pkg::xlen_word_t req_rs2_i,
	output logic                   resp_valid_o,
	input  logic                   resp_ready_i,
	output muldiv_pkg::xlen_word_t resp_result_o
);
	import muldiv_pkg::*;

	logic       mul_start;
	logic       div_start;
	logic       signed1;
	logic       signed2;
	logic       mul_done;
	logic       div_done;
	dword_t     product;
	xlen_word_t quotient;
	xlen_word_t remainder;

	muldiv_ctrl i_ctrl (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.req_valid_i   (req_valid_i),
		.req_ready_o   (req_ready_o),
		.req_op_i      (req_op_i),
		.resp_valid_o  (resp_valid_o),
		.resp_ready_i  (resp_ready_i),
		.resp_result_o (resp_result_o),
		.mul_start_o   (mul_start),
		.div_start_o   (div_start),
		.signed1_o     (signed1),
		.signed2_o     (signed2),
		.mul_done_i    (mul_done),
		.div_done_i    (div_done),
		.product_i     (product),
		.quotient_i    (quotient),
		.remainder_i   (remainder)
	);

	mul_unit i_mul (
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.start_i        (mul_start),
		.signed1_i      (signed1),
		.signed2_i      (signed2),
		.multiplicand_i (req_rs1_i),
		.multiplier_i   (req_rs2_i),
		.done_o         (mul_done),
		.product_o      (product)
	);

	// divide ops are signed on both operands or neither
	div_unit i_div (
		.clk_i           (clk_i),
		.rst_n_i         (rst_n_i),
		.start_i         (div_start),
		.inputs_signed_i (signed1),
		.dividend_i      (req_rs1_i),
		.divisor_i       (req_rs2_i),
		.done_o          (div_done),
		.quotient_o      (quotient),
		.remainder_o     (remainder)
	);

endmodule

/* source/muldiv_ctrl.sv */
module muldiv_ctrl (
	input  logic                   clk_i,
	input  logic                   rst_n_i,
	input  logic                   req_valid_i,
	output logic                   req_ready_o,
	input  muldiv_pkg::muldiv_op_t req_op_i,
	output logic                   resp_valid_o,
	input  logic                   resp_ready_i,
	output muldiv_pkg::xlen_word_t resp_result_o,
	output logic                   mul_start_o,
	output logic                   div_start_o,
	output logic                   signed1_o,
	output logic                   signed2_o,
	input  logic                   mul_done_i,
	input  logic                   div_done_i,
	input  muldiv_pkg::dword_t     product_i,
	input  muldiv_pkg::xlen_word_t quotient_i,
	input  muldiv_pkg::xlen_word_t remainder_i
);
	import muldiv_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_busy,
		st_resp
	} ctrl_state_t;

	ctrl_state_t state_q;
	muldiv_op_t  op_q;
	muldiv_op_t  op_sel;
	logic        accept;
	logic        is_div;
	logic        hi_sel;
	logic        rem_sel;
	logic        unit_done;
	xlen_word_t  result_sel;

	assign req_ready_o = (state_q == st_idle);
	assign resp_valid_o = (state_q == st_resp);
	assign accept = req_valid_i && req_ready_o;

	// units sample operands on the accept edge, so start comes straight from the request
	assign mul_start_o = accept && !req_op_i[2];
	assign div_start_o = accept && req_op_i[2];

	// live request while idle, latched op afterwards
	assign op_sel = (state_q == st_idle) ? req_op_i : op_q;

	always_comb begin
		case (op_sel)
			op_mulh, op_div, op_rem: begin
				signed1_o = 1'b1;
				signed2_o = 1'b1;
			end
			op_mulhsu: begin
				signed1_o = 1'b1;
				signed2_o = 1'b0;
			end
			default: begin
				signed1_o = 1'b0;
				signed2_o = 1'b0;
			end
		endcase
	end

	// decode of the latched op
	assign is_div = op_q[2];
	assign rem_sel = op_q[1];
	assign hi_sel = (op_q[1:0] != 2'b00);

	assign unit_done = is_div ? div_done_i : mul_done_i;

	always_comb begin
		if (is_div)
			result_sel = rem_sel ? remainder_i : quotient_i;
		else if (hi_sel)
			result_sel = product_i[2*XLEN-1:XLEN];
		else
			result_sel = product_i[XLEN-1:0];
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q <= st_idle;
		end else begin
			unique case (state_q)
				st_idle: begin
					if (accept)
						state_q <= st_busy;
				end
				st_busy: begin
					if (unit_done)
						state_q <= st_resp;
				end
				st_resp: begin
					if (resp_ready_i)
						state_q <= st_idle;
				end
				default: state_q <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept)
			op_q <= req_op_i;
		if (state_q == st_busy && unit_done)
			resp_result_o <= result_sel;
	end

	// held response must not change under back-pressure
	a_resp_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_result_o));

endmodule

/* source/div_unit.sv */
module div_unit (
	input  logic                   clk_i,
	input  logic                   rst_n_i,
	input  logic                   start_i,
	input  logic                   inputs_signed_i,
	input  muldiv_pkg::xlen_word_t dividend_i,
	input  muldiv_pkg::xlen_word_t divisor_i,
	output logic                   done_o,
	output muldiv_pkg::xlen_word_t quotient_o,
	output muldiv_pkg::xlen_word_t remainder_o
);
	import muldiv_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_sign,
		st_iter
	} div_state_t;

	div_state_t       state_q;
	logic [CNT_W-1:0] cnt_q;
	logic             signed_q;
	logic             neg_quo_q;
	logic             neg_rem_q;
	xlen_word_t       dvd_q;
	xlen_word_t       dvs_q;
	xlen_word_t       quo_q;
	xlen_word_t       rem_q;

	logic             dvd_neg;
	logic             dvs_neg;
	logic             div_by_zero;
	logic             overflow;
	logic             last_step;
	logic [XLEN:0]    rem_shift;
	logic             fits;
	xlen_word_t       quo_next;
	xlen_word_t       rem_next;

	assign dvd_neg = signed_q && dvd_q[XLEN-1];
	assign dvs_neg = signed_q && dvs_q[XLEN-1];
	assign div_by_zero = (dvs_q == '0);
	// most negative value divided by -1
	assign overflow = signed_q && (dvd_q == {1'b1, {(XLEN-1){1'b0}}}) && (dvs_q == '1);
	assign last_step = (cnt_q == CNT_W'(1));

	// restoring step, dividend bits shift out of the quotient register
	assign rem_shift = {rem_q, quo_q[XLEN-1]};
	assign fits = (rem_shift >= {1'b0, dvs_q});
	assign rem_next = fits ? (rem_shift[XLEN-1:0] - dvs_q) : rem_shift[XLEN-1:0];
	assign quo_next = {quo_q[XLEN-2:0], fits};

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q <= st_idle;
			cnt_q <= '0;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			unique case (state_q)
				st_idle: begin
					if (start_i)
						state_q <= st_sign;
				end
				st_sign: begin
					cnt_q <= CNT_W'(XLEN);
					if (div_by_zero || overflow) begin
						state_q <= st_idle;
						done_o <= 1'b1;
					end else begin
						state_q <= st_iter;
					end
				end
				st_iter: begin
					cnt_q <= cnt_q - 1'b1;
					if (last_step) begin
						state_q <= st_idle;
						done_o <= 1'b1;
					end
				end
				default: state_q <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		unique case (state_q)
			st_idle: begin
				if (start_i) begin
					signed_q <= inputs_signed_i;
					dvd_q <= dividend_i;
					dvs_q <= divisor_i;
				end
			end
			st_sign: begin
				neg_quo_q <= dvd_neg ^ dvs_neg;
				// remainder follows the dividend
				neg_rem_q <= dvd_neg;
				quo_q <= dvd_neg ? -dvd_q : dvd_q;
				dvs_q <= dvs_neg ? -dvs_q : dvs_q;
				rem_q <= '0;
				if (div_by_zero) begin
					quotient_o <= '1;
					remainder_o <= dvd_q;
				end else if (overflow) begin
					quotient_o <= dvd_q;
					remainder_o <= '0;
				end
			end
			st_iter: begin
				quo_q <= quo_next;
				rem_q <= rem_next;
				if (last_step) begin
					quotient_o <= neg_quo_q ? -quo_next : quo_next;
					remainder_o <= neg_rem_q ? -rem_next : rem_next;
				end
			end
			default: ;
		endcase
	end

	a_start_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		start_i |-> state_q == st_idle);

endmodule

/* source/mul_unit.sv */
module mul_unit (
	input  logic                   clk_i,
	input  logic                   rst_n_i,
	input  logic                   start_i,
	input  logic                   signed1_i,
	input  logic                   signed2_i,
	input  muldiv_pkg::xlen_word_t multiplicand_i,
	input  muldiv_pkg::xlen_word_t multiplier_i,
	output logic                   done_o,
	output muldiv_pkg::dword_t     product_o
);
	import muldiv_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_sign,
		st_iter
	} mul_state_t;

	mul_state_t       state_q;
	logic [CNT_W-1:0] cnt_q;
	logic             signed1_q;
	logic             signed2_q;
	logic             neg_q;
	xlen_word_t       op_a_q;
	xlen_word_t       op_b_q;
	dword_t           prod_q;

	logic             a_neg;
	logic             b_neg;
	logic             last_step;
	logic [XLEN:0]    sum;
	dword_t           prod_next;

	assign a_neg = signed1_q && op_a_q[XLEN-1];
	assign b_neg = signed2_q && op_b_q[XLEN-1];
	assign last_step = (cnt_q == CNT_W'(1));

	// add the multiplicand into the upper half when the lsb is set, then shift right
	assign sum = prod_q[0] ? ({1'b0, prod_q[2*XLEN-1:XLEN]} + {1'b0, op_a_q})
	                       : {1'b0, prod_q[2*XLEN-1:XLEN]};
	assign prod_next = {sum, prod_q[XLEN-1:1]};

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q <= st_idle;
			cnt_q <= '0;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			unique case (state_q)
				st_idle: begin
					if (start_i)
						state_q <= st_sign;
				end
				st_sign: begin
					cnt_q <= CNT_W'(XLEN);
					state_q <= st_iter;
				end
				st_iter: begin
					cnt_q <= cnt_q - 1'b1;
					if (last_step) begin
						state_q <= st_idle;
						done_o <= 1'b1;
					end
				end
				default: state_q <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		unique case (state_q)
			st_idle: begin
				if (start_i) begin
					signed1_q <= signed1_i;
					signed2_q <= signed2_i;
					op_a_q <= multiplicand_i;
					op_b_q <= multiplier_i;
				end
			end
			st_sign: begin
				// work on magnitudes, sign fixed up at the end
				neg_q <= a_neg ^ b_neg;
				op_a_q <= a_neg ? -op_a_q : op_a_q;
				prod_q <= {{XLEN{1'b0}}, (b_neg ? -op_b_q : op_b_q)};
			end
			st_iter: begin
				prod_q <= prod_next;
				if (last_step)
					product_o <= neg_q ? -prod_next : prod_next;
			end
			default: ;
		endcase
	end

	// one operation at a time
	a_start_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		start_i |-> state_q == st_idle);

endmodule

/* source/muldiv_pkg.sv */
package muldiv_pkg;

	// data path width of the integer core
	localparam int XLEN = 32;

	// iteration counter, must hold the value XLEN itself
	localparam int CNT_W = $clog2(XLEN + 1);

	typedef logic [XLEN-1:0] xlen_word_t;

	// full width product
	typedef logic [2*XLEN-1:0] dword_t;

	// funct3 of the RV32M group
	// bit 2 picks divide, bit 1 picks remainder on the divide side
	typedef enum logic [2:0] {
		op_mul    = 3'b000,
		op_mulh   = 3'b001,
		op_mulhsu = 3'b010,
		op_mulhu  = 3'b011,
		op_div    = 3'b100,
		op_divu   = 3'b101,
		op_rem    = 3'b110,
		op_remu   = 3'b111
	} muldiv_op_t;

endpackage
